// ==== src/misc_pkg.sv ====
// misc pipe shared definitions
// widths, op encodings, csr map and the op-field union
package misc_pkg;

  localparam int XLEN   = 32;
  localparam int OP_W   = 5;
  localparam int CSR_AW = 14;
  localparam int RD_W   = 5;  // architectural register index

  typedef enum logic [1:0] {
    BR   = 2'd0,
    PRIV = 2'd1,
    CNT  = 2'd2
  } instr_type_e;

  typedef enum logic [OP_W-1:0] {
    BEQ  = 5'd0,
    BNE  = 5'd1,
    BLT  = 5'd2,
    BGE  = 5'd3,
    BLTU = 5'd4,
    BGEU = 5'd5,
    B    = 5'd6,
    BL   = 5'd7,
    JIRL = 5'd8
  } br_op_e;

  typedef enum logic [OP_W-1:0] {
    CSRRD   = 5'd0,
    CSRWR   = 5'd1,
    CSRXCHG = 5'd2,
    ERTN    = 5'd3,
    IDLE    = 5'd4
  } priv_op_e;

  typedef enum logic [OP_W-1:0] {
    RDCNTVL = 5'd0,
    RDCNTVH = 5'd1,
    RDCNTID = 5'd2
  } cnt_op_e;

  // one op word, member picked by instr_type_e
  typedef union packed {
    br_op_e   br;
    priv_op_e priv;
    cnt_op_e  cnt;
  } misc_op_u;

  // implemented csrs, anything else reads zero
  localparam logic [CSR_AW-1:0] CSR_CRMD  = 14'h000;
  localparam logic [CSR_AW-1:0] CSR_ERA   = 14'h006;
  localparam logic [CSR_AW-1:0] CSR_SAVE0 = 14'h030;
  localparam logic [CSR_AW-1:0] CSR_TID   = 14'h040;
  localparam int                CSR_NUM   = 4;

  localparam logic [XLEN-1:0] TID_RESET = 32'h0000_0005;

endpackage

// ==== src/misc_if.sv ====
// issue and writeback bundles of the misc pipe

interface misc_issue_if;
  logic                          valid;
  misc_pkg::instr_type_e         instr_type;
  misc_pkg::misc_op_u            op;
  logic [misc_pkg::XLEN-1:0]     src0;
  logic [misc_pkg::XLEN-1:0]     src1;
  logic [misc_pkg::XLEN-1:0]     imm;
  logic [misc_pkg::XLEN-1:0]     pc;
  logic [misc_pkg::XLEN-1:0]     npc;  // predicted next pc
  logic [misc_pkg::RD_W-1:0]     rd;
  logic                          rd_valid;
  logic                          ready;

  modport pipe (
    input  valid, instr_type, op, src0, src1, imm, pc, npc, rd, rd_valid,
    output ready
  );
endinterface

interface misc_wb_if;
  logic                          valid;
  logic                          we;
  logic [misc_pkg::RD_W-1:0]     rd;
  logic [misc_pkg::XLEN-1:0]     wdata;
  logic                          redirect;
  logic [misc_pkg::XLEN-1:0]     target;
  logic                          csr_we;
  logic [misc_pkg::CSR_AW-1:0]   csr_addr;
  logic [misc_pkg::XLEN-1:0]     csr_wdata;
  logic                          ertn;
  logic                          idle;
  logic                          ready;

  modport src (
    output valid, we, rd, wdata, redirect, target, csr_we, csr_addr, csr_wdata, ertn, idle,
    input  ready
  );

  // commit watchers
  modport mon (
    input valid, we, rd, wdata, redirect, target, csr_we, csr_addr, csr_wdata, ertn, idle,
    input ready
  );
endinterface

// ==== src/branch_unit.sv ====
// branch resolution
// compare, target and mispredict check against the predicted npc

module branch_unit (
  input  logic                      valid_i,
  input  misc_pkg::br_op_e          op_i,
  input  logic [misc_pkg::XLEN-1:0] pc_i,
  input  logic [misc_pkg::XLEN-1:0] npc_i,
  input  logic [misc_pkg::XLEN-1:0] imm_i,
  input  logic [misc_pkg::XLEN-1:0] src0_i,
  input  logic [misc_pkg::XLEN-1:0] src1_i,
  output logic                      taken_o,
  output logic [misc_pkg::XLEN-1:0] target_o,
  output logic                      redirect_o
);

  logic                      eq;
  logic                      lt_s;
  logic                      lt_u;
  logic                      cond;
  logic [misc_pkg::XLEN-1:0] fall_pc;
  logic [misc_pkg::XLEN-1:0] next_pc;

  assign eq   = (src0_i == src1_i);
  assign lt_s = ($signed(src0_i) < $signed(src1_i));
  assign lt_u = (src0_i < src1_i);

  always_comb begin
    case (op_i)
      misc_pkg::BEQ:  cond = eq;
      misc_pkg::BNE:  cond = ~eq;
      misc_pkg::BLT:  cond = lt_s;
      misc_pkg::BGE:  cond = ~lt_s;
      misc_pkg::BLTU: cond = lt_u;
      misc_pkg::BGEU: cond = ~lt_u;
      misc_pkg::B,
      misc_pkg::BL,
      misc_pkg::JIRL: cond = 1'b1;  // unconditional
      default:        cond = 1'b0;
    endcase
  end

  // jirl is register indirect
  assign target_o = (op_i == misc_pkg::JIRL) ? src0_i + imm_i : pc_i + imm_i;
  assign fall_pc  = pc_i + misc_pkg::XLEN'(4);
  assign taken_o  = valid_i & cond;
  assign next_pc  = taken_o ? target_o : fall_pc;

  // mispredict when resolved pc differs from the predicted one
  assign redirect_o = valid_i & (next_pc != npc_i);

endmodule

// ==== src/stable_counter.sv ====
// stable counter
// free-running 64-bit time base, wraps at the top

module stable_counter (
  input  logic        clk,
  input  logic        rst_n,
  output logic [63:0] value_o
);

  logic [63:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 64'd1;  // wraps naturally
    end
  end

  assign value_o = cnt_q;

endmodule

// ==== src/csr_regs.sv ====
// small csr file
// combinational read in s0, write on a committed record with csr_we

module csr_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [misc_pkg::CSR_AW-1:0] raddr_i,
  output logic [misc_pkg::XLEN-1:0]   rdata_o,
  misc_wb_if.mon                      commit,
  output logic [misc_pkg::XLEN-1:0]   era_o
);

  // slot order: crmd, era, save0, tid
  logic [misc_pkg::XLEN-1:0]  csr_q [misc_pkg::CSR_NUM];
  logic [misc_pkg::CSR_NUM-1:0] rsel;
  logic [misc_pkg::CSR_NUM-1:0] wsel;
  logic                         wr_en;

  // one-hot slot select, all zero on a miss
  function automatic logic [misc_pkg::CSR_NUM-1:0] csr_sel(
    input logic [misc_pkg::CSR_AW-1:0] addr
  );
    logic [misc_pkg::CSR_NUM-1:0] sel;
    sel = '0;
    case (addr)
      misc_pkg::CSR_CRMD:  sel[0] = 1'b1;
      misc_pkg::CSR_ERA:   sel[1] = 1'b1;
      misc_pkg::CSR_SAVE0: sel[2] = 1'b1;
      misc_pkg::CSR_TID:   sel[3] = 1'b1;
      default:             sel    = '0;
    endcase
    return sel;
  endfunction

  assign rsel  = csr_sel(raddr_i);
  assign wsel  = csr_sel(commit.csr_addr);
  assign wr_en = commit.valid & commit.ready & commit.csr_we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < misc_pkg::CSR_NUM; i++) begin
        csr_q[i] <= (i == 3) ? misc_pkg::TID_RESET : '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < misc_pkg::CSR_NUM; i++) begin
        if (wsel[i]) csr_q[i] <= commit.csr_wdata;
      end
    end
  end

  always_comb begin
    rdata_o = '0;  // unimplemented reads zero
    for (int i = 0; i < misc_pkg::CSR_NUM; i++) begin
      if (rsel[i]) rdata_o = csr_q[i];
    end
  end

  assign era_o = csr_q[1];

endmodule

// ==== src/idle_fsm.sv ====
// run/idle state machine
// blocks issue after an idle commits, wakes on the wake pulse

module idle_fsm (
  input  logic   clk,
  input  logic   rst_n,
  misc_wb_if.mon commit,
  input  logic   wake_i,
  output logic   issue_allow_o,
  output logic   idle_o
);

  logic idle_q;   // state bit, 0 = RUN, 1 = IDLE
  logic idle_d;
  logic allow_q;
  logic idle_commit;

  assign idle_commit = commit.valid & commit.ready & commit.idle;

  // RUN -> IDLE on idle commit
  // IDLE -> RUN on wake, wake ignored in RUN
  always_comb begin
    idle_d = idle_q;
    if (!idle_q && idle_commit) begin
      idle_d = 1'b1;
    end else if (idle_q && wake_i) begin
      idle_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_q  <= 1'b0;
      allow_q <= 1'b1;
    end else begin
      idle_q  <= idle_d;
      allow_q <= ~idle_d;  // registered copy for the issue gate
    end
  end

  assign idle_o        = idle_q;
  assign issue_allow_o = allow_q;

endmodule

// ==== src/misc_pipe.sv ====
// misc execution pipe
// s0 accept and csr/counter sample, s1 execute, s2 writeback record

module misc_pipe (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,
  misc_issue_if.pipe                  issue,
  misc_wb_if.src                      wb,
  input  logic                        issue_allow_i,
  output logic [misc_pkg::CSR_AW-1:0] csr_raddr_o,
  input  logic [misc_pkg::XLEN-1:0]   csr_rdata_i,
  input  logic [63:0]                 cnt_value_i,
  input  logic [misc_pkg::XLEN-1:0]   era_i
);

  logic s1_ready;
  logic s2_ready;
  logic issue_fire;

  // ======================== stage 0 =========================
  assign issue.ready = s1_ready & issue_allow_i;
  assign issue_fire  = issue.valid & issue.ready;

  // rdcntid reads TID through the csr port
  assign csr_raddr_o = (issue.instr_type == misc_pkg::CNT && issue.op.cnt == misc_pkg::RDCNTID)
                       ? misc_pkg::CSR_TID : issue.imm[misc_pkg::CSR_AW-1:0];

  // ======================== stage 1 =========================
  logic                      s1_valid;
  misc_pkg::instr_type_e     s1_type;
  misc_pkg::misc_op_u        s1_op;
  logic [misc_pkg::XLEN-1:0] s1_src0;
  logic [misc_pkg::XLEN-1:0] s1_src1;
  logic [misc_pkg::XLEN-1:0] s1_imm;
  logic [misc_pkg::XLEN-1:0] s1_pc;
  logic [misc_pkg::XLEN-1:0] s1_npc;
  logic [misc_pkg::RD_W-1:0] s1_rd;
  logic                      s1_rd_valid;
  logic [misc_pkg::XLEN-1:0] s1_csr_rdata;
  logic [63:0]               s1_cnt;

  assign s1_ready = s2_ready | ~s1_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= issue.valid & issue_allow_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      s1_type      <= issue.instr_type;
      s1_op        <= issue.op;
      s1_src0      <= issue.src0;
      s1_src1      <= issue.src1;
      s1_imm       <= issue.imm;
      s1_pc        <= issue.pc;
      s1_npc       <= issue.npc;
      s1_rd        <= issue.rd;
      s1_rd_valid  <= issue.rd_valid;
      s1_csr_rdata <= csr_rdata_i;  // sampled at accept
      s1_cnt       <= cnt_value_i;
    end
  end

  logic                      s1_is_br;
  logic                      s1_is_priv;
  logic [misc_pkg::XLEN-1:0] s1_link;
  logic                      s1_csr_we;
  logic [misc_pkg::XLEN-1:0] s1_csr_wdata;
  logic                      s1_ertn;
  logic                      s1_idle;
  logic [misc_pkg::XLEN-1:0] s1_cnt_sel;
  logic [misc_pkg::XLEN-1:0] s1_wdata;
  logic                      s1_redirect;
  logic [misc_pkg::XLEN-1:0] s1_target;
  logic                      br_taken;
  logic                      br_redirect;
  logic [misc_pkg::XLEN-1:0] br_target;

  assign s1_is_br   = (s1_type == misc_pkg::BR);
  assign s1_is_priv = (s1_type == misc_pkg::PRIV);
  assign s1_link    = s1_pc + misc_pkg::XLEN'(4);  // bl/jirl link

  assign s1_csr_we = s1_is_priv &
                     (s1_op.priv == misc_pkg::CSRWR | s1_op.priv == misc_pkg::CSRXCHG);
  // xchg: mask bit set takes src0, clear keeps old
  assign s1_csr_wdata = (s1_op.priv == misc_pkg::CSRXCHG)
                        ? (s1_csr_rdata & ~s1_src1) | (s1_src0 & s1_src1) : s1_src0;
  assign s1_ertn = s1_is_priv & (s1_op.priv == misc_pkg::ERTN);
  assign s1_idle = s1_is_priv & (s1_op.priv == misc_pkg::IDLE);

  always_comb begin
    case (s1_op.cnt)
      misc_pkg::RDCNTVL: s1_cnt_sel = s1_cnt[31:0];
      misc_pkg::RDCNTVH: s1_cnt_sel = s1_cnt[63:32];
      misc_pkg::RDCNTID: s1_cnt_sel = s1_csr_rdata;  // TID
      default:           s1_cnt_sel = '0;
    endcase
  end

  always_comb begin
    case (s1_type)
      misc_pkg::BR:   s1_wdata = s1_link;
      misc_pkg::PRIV: s1_wdata = s1_csr_rdata;  // old csr value
      misc_pkg::CNT:  s1_wdata = s1_cnt_sel;
      default:        s1_wdata = '0;
    endcase
  end

  branch_unit u_branch (
    .valid_i    (s1_valid & s1_is_br),
    .op_i       (s1_op.br),
    .pc_i       (s1_pc),
    .npc_i      (s1_npc),
    .imm_i      (s1_imm),
    .src0_i     (s1_src0),
    .src1_i     (s1_src1),
    .taken_o    (br_taken),
    .target_o   (br_target),
    .redirect_o (br_redirect)
  );

  assign s1_redirect = s1_ertn | br_redirect;
  assign s1_target   = s1_ertn ? era_i : (br_taken ? br_target : s1_link);

  // ======================== stage 2 =========================
  assign s2_ready = ~wb.valid | wb.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.valid    <= 1'b0;
      wb.we       <= 1'b0;
      wb.redirect <= 1'b0;
      wb.csr_we   <= 1'b0;
      wb.ertn     <= 1'b0;
      wb.idle     <= 1'b0;
    end else if (flush_i) begin
      wb.valid    <= 1'b0;
      wb.we       <= 1'b0;
      wb.redirect <= 1'b0;
      wb.csr_we   <= 1'b0;
      wb.ertn     <= 1'b0;
      wb.idle     <= 1'b0;
    end else if (s2_ready) begin
      wb.valid    <= s1_valid;
      wb.we       <= s1_valid & s1_rd_valid;
      wb.redirect <= s1_valid & s1_redirect;
      wb.csr_we   <= s1_valid & s1_csr_we;
      wb.ertn     <= s1_valid & s1_ertn;
      wb.idle     <= s1_valid & s1_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready && s1_valid) begin
      wb.rd        <= s1_rd;
      wb.wdata     <= s1_wdata;
      wb.target    <= s1_target;
      wb.csr_addr  <= s1_imm[misc_pkg::CSR_AW-1:0];
      wb.csr_wdata <= s1_csr_wdata;
    end
  end

endmodule

// ==== src/misc_unit_top.sv ====
// misc unit top level
// plain ports onto the issue/wb bundles, pipe plus csr, counter and idle control

module misc_unit_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,
  input  logic                        wake_i,
  input  logic                        issue_valid_i,
  input  logic [1:0]                  issue_type_i,
  input  logic [misc_pkg::OP_W-1:0]   issue_op_i,
  input  logic [misc_pkg::XLEN-1:0]   issue_src0_i,
  input  logic [misc_pkg::XLEN-1:0]   issue_src1_i,
  input  logic [misc_pkg::XLEN-1:0]   issue_imm_i,
  input  logic [misc_pkg::XLEN-1:0]   issue_pc_i,
  input  logic [misc_pkg::XLEN-1:0]   issue_npc_i,
  input  logic [misc_pkg::RD_W-1:0]   issue_rd_i,
  input  logic                        issue_rd_valid_i,
  output logic                        issue_ready_o,
  output logic                        wb_valid_o,
  output logic                        wb_we_o,
  output logic [misc_pkg::RD_W-1:0]   wb_rd_o,
  output logic [misc_pkg::XLEN-1:0]   wb_wdata_o,
  output logic                        wb_redirect_o,
  output logic [misc_pkg::XLEN-1:0]   wb_target_o,
  output logic                        wb_ertn_o,
  output logic                        wb_idle_o,
  input  logic                        wb_ready_i,
  output logic                        idle_o
);

  misc_issue_if issue_if ();
  misc_wb_if    wb_if ();

  logic                        issue_allow;
  logic [misc_pkg::CSR_AW-1:0] csr_raddr;
  logic [misc_pkg::XLEN-1:0]   csr_rdata;
  logic [misc_pkg::XLEN-1:0]   era;
  logic [63:0]                 cnt_value;

  // issue side
  assign issue_if.valid      = issue_valid_i;
  assign issue_if.instr_type = misc_pkg::instr_type_e'(issue_type_i);
  assign issue_if.op         = misc_pkg::misc_op_u'(issue_op_i);
  assign issue_if.src0       = issue_src0_i;
  assign issue_if.src1       = issue_src1_i;
  assign issue_if.imm        = issue_imm_i;
  assign issue_if.pc         = issue_pc_i;
  assign issue_if.npc        = issue_npc_i;
  assign issue_if.rd         = issue_rd_i;
  assign issue_if.rd_valid   = issue_rd_valid_i;
  assign issue_ready_o       = issue_if.ready;

  // writeback side
  assign wb_if.ready   = wb_ready_i;
  assign wb_valid_o    = wb_if.valid;
  assign wb_we_o       = wb_if.we;
  assign wb_rd_o       = wb_if.rd;
  assign wb_wdata_o    = wb_if.wdata;
  assign wb_redirect_o = wb_if.redirect;
  assign wb_target_o   = wb_if.target;
  assign wb_ertn_o     = wb_if.ertn;
  assign wb_idle_o     = wb_if.idle;

  misc_pipe u_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .issue         (issue_if.pipe),
    .wb            (wb_if.src),
    .issue_allow_i (issue_allow),
    .csr_raddr_o   (csr_raddr),
    .csr_rdata_i   (csr_rdata),
    .cnt_value_i   (cnt_value),
    .era_i         (era)
  );

  csr_regs u_csr (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (csr_raddr),
    .rdata_o (csr_rdata),
    .commit  (wb_if.mon),
    .era_o   (era)
  );

  stable_counter u_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .value_o (cnt_value)
  );

  idle_fsm u_idle (
    .clk           (clk),
    .rst_n         (rst_n),
    .commit        (wb_if.mon),
    .wake_i        (wake_i),
    .issue_allow_o (issue_allow),
    .idle_o        (idle_o)
  );

endmodule

// ==== verif/misc_unit_asserts.sv ====
// misc pipe protocol checks
// bound into misc_pipe to watch the wb record and the issue gate

module misc_unit_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic        flush_i,
  input logic        wb_valid,
  input logic        wb_ready,
  input logic        wb_we,
  input logic [4:0]  wb_rd,
  input logic [31:0] wb_wdata,
  input logic        wb_redirect,
  input logic [31:0] wb_target,
  input logic        s1_valid,
  input logic        issue_allow_i
);

  // a stalled record must hold until taken
  property stall_hold_p;
    @(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready && !flush_i) |=>
        (wb_valid && $stable(wb_we) && $stable(wb_rd) && $stable(wb_wdata)
         && $stable(wb_redirect) && $stable(wb_target));
  endproperty
  stall_hold_a: assert property (stall_hold_p)
    else $error("wb record changed while stalled");

  // reset or flush leaves stage 2 empty
  clear_a: assert property (@(posedge clk) (!rst_n || flush_i) |=> !wb_valid)
    else $error("wb valid right after reset or flush");

  // nothing enters an empty s1 while issue is blocked
  allow_a: assert property (@(posedge clk) disable iff (!rst_n)
                            (!issue_allow_i && !s1_valid) |=> !s1_valid)
    else $error("instruction accepted while issue not allowed");

endmodule

bind misc_pipe misc_unit_asserts u_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .flush_i       (flush_i),
  .wb_valid      (wb.valid),
  .wb_ready      (wb.ready),
  .wb_we         (wb.we),
  .wb_rd         (wb.rd),
  .wb_wdata      (wb.wdata),
  .wb_redirect   (wb.redirect),
  .wb_target     (wb.target),
  .s1_valid      (s1_valid),
  .issue_allow_i (issue_allow_i)
);

// ==== verif/misc_unit_tb.sv ====
// misc unit testbench
// branch, csr, counter, back-pressure, idle and flush runs against a reference model

module misc_unit_tb;

  localparam int TMO = 200;  // cycles per wait

  typedef struct packed {
    logic        we;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        redirect;
    logic [31:0] target;
    logic        ertn;
    logic        idle;
    logic        csr_we;
    logic [13:0] csr_addr;
    logic [31:0] csr_wdata;
    logic        cnt_vl;  // value only checked for growth
  } exp_t;

  logic clk, rst_n, flush_i, wake_i;
  logic issue_valid_i, issue_rd_valid_i, issue_ready_o, wb_ready_i, idle_o;
  logic [1:0]  issue_type_i;
  logic [4:0]  issue_op_i, issue_rd_i, wb_rd_o;
  logic [31:0] issue_src0_i, issue_src1_i, issue_imm_i, issue_pc_i, issue_npc_i;
  logic        wb_valid_o, wb_we_o, wb_redirect_o, wb_ertn_o, wb_idle_o;
  logic [31:0] wb_wdata_o, wb_target_o;

  exp_t        exp_q[$];
  logic [31:0] shadow_csr [4];
  logic [31:0] last_vl;
  integer      seed = 32'h2dcf;
  int          errors, checks, issued, committed, flushed;
  int          ready_mode;  // pattern for wb_ready_i

  misc_unit_top dut0 (.*);

  always #20 clk = ~clk;

  always @(negedge clk) begin
    if (ready_mode == 1) wb_ready_i <= $random(seed);
    else wb_ready_i <= (ready_mode == 0);
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR time=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  function automatic int csr_slot(input logic [13:0] addr);
    case (addr)
      misc_pkg::CSR_CRMD:  return 0;
      misc_pkg::CSR_ERA:   return 1;
      misc_pkg::CSR_SAVE0: return 2;
      misc_pkg::CSR_TID:   return 3;
      default:             return -1;
    endcase
  endfunction

  function automatic logic [31:0] branch_next(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] imm,
                                              input logic [31:0] pc);
    logic taken;
    case (op)
      misc_pkg::BEQ:  taken = (a == b);
      misc_pkg::BNE:  taken = (a != b);
      misc_pkg::BLT:  taken = ($signed(a) < $signed(b));
      misc_pkg::BGE:  taken = ($signed(a) >= $signed(b));
      misc_pkg::BLTU: taken = (a < b);
      misc_pkg::BGEU: taken = (a >= b);
      default:        taken = 1'b1;
    endcase
    if (!taken) return pc + 4;
    return (op == misc_pkg::JIRL) ? a + imm : pc + imm;
  endfunction

  function automatic exp_t ref_exec(input logic [1:0] typ, input logic [4:0] op,
                                    input logic [31:0] a, input logic [31:0] b,
                                    input logic [31:0] imm, input logic [31:0] pc,
                                    input logic [31:0] npc, input logic [4:0] rd,
                                    input logic rd_valid);
    exp_t e;
    logic [31:0] old;
    int s;
    e = '0;
    e.we = rd_valid;
    e.rd = rd;
    s = csr_slot(imm[13:0]);
    old = (s < 0) ? 32'h0 : shadow_csr[s];
    if (typ == misc_pkg::BR) begin
      e.wdata = pc + 4;  // link
      e.target = branch_next(op, a, b, imm, pc);
      e.redirect = (e.target != npc);
    end else if (typ == misc_pkg::PRIV) begin
      e.wdata = old;
      e.csr_addr = imm[13:0];
      e.csr_we = (op == misc_pkg::CSRWR) || (op == misc_pkg::CSRXCHG);
      e.csr_wdata = a;
      if (op == misc_pkg::CSRXCHG) begin
        for (int i = 0; i < 32; i++) begin
          e.csr_wdata[i] = b[i] ? a[i] : old[i];  // mask bit picks the new bit
        end
      end
      e.ertn = (op == misc_pkg::ERTN);
      e.idle = (op == misc_pkg::IDLE);
      e.redirect = e.ertn;
      e.target = shadow_csr[1];
    end else begin
      e.cnt_vl = (op == misc_pkg::RDCNTVL);
      e.wdata = (op == misc_pkg::RDCNTID) ? shadow_csr[3] : 32'h0;  // vh is zero early on
    end
    return e;
  endfunction

  // ============================================================
  // compare process
  // ============================================================
  always @(posedge clk) begin : compare
    exp_t e;
    int s;
    if (rst_n && wb_valid_o && wb_ready_i) begin
      committed++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected commit at time %0t", $time);
      end else begin
        e = exp_q.pop_front();
        check_val("wb_we_o", wb_we_o, e.we);
        if (e.we) begin
          check_val("wb_rd_o", wb_rd_o, e.rd);
          if (e.cnt_vl) begin
            check_val("rdcntvl_increase", wb_wdata_o > last_vl, 1);
            last_vl = wb_wdata_o;
          end else begin
            check_val("wb_wdata_o", wb_wdata_o, e.wdata);
          end
        end
        check_val("wb_redirect_o", wb_redirect_o, e.redirect);
        if (e.redirect) check_val("wb_target_o", wb_target_o, e.target);
        check_val("wb_ertn_o", wb_ertn_o, e.ertn);
        check_val("wb_idle_o", wb_idle_o, e.idle);
        s = csr_slot(e.csr_addr);
        if (e.csr_we && s >= 0) shadow_csr[s] = e.csr_wdata;
      end
    end
  end

  // starts and returns on a falling edge
  task automatic issue_instr(input logic [1:0] typ, input logic [4:0] op, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] imm,
                             input logic [31:0] pc, input logic [31:0] npc,
                             input logic [4:0] rd, input logic rd_valid);
    int waited;
    issue_valid_i = 1;
    issue_type_i = typ;
    issue_op_i = op;
    issue_src0_i = a;
    issue_src1_i = b;
    issue_imm_i = imm;
    issue_pc_i = pc;
    issue_npc_i = npc;
    issue_rd_i = rd;
    issue_rd_valid_i = rd_valid;
    waited = 0;
    #1;
    while (!issue_ready_o && waited < TMO) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (waited >= TMO) begin
      errors++;
      $display("timeout: issue was never accepted");
    end else begin
      @(posedge clk);
      exp_q.push_back(ref_exec(typ, op, a, b, imm, pc, npc, rd, rd_valid));
      issued++;
    end
    @(negedge clk);
    issue_valid_i = 0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TMO) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= TMO) begin
      errors++;
      $display("timeout: expected records never committed");
    end
  endtask

  task automatic rand_branch(input logic [4:0] op);
    logic [31:0] a, b, imm, pc, good;
    logic        hit;
    a = $random(seed);
    b = ($random(seed) & 1) ? a : $random(seed);
    imm = $random(seed);
    imm = {{20{imm[11]}}, imm[11:2], 2'b00};
    pc = $random(seed) & 32'hffff_fffc;
    good = branch_next(op, a, b, imm, pc);
    hit = $random(seed);
    issue_instr(misc_pkg::BR, op, a, b, imm, pc, hit ? good : good + 8, op[4:0] + 5'd1,
                op == misc_pkg::BL || op == misc_pkg::JIRL);
  endtask

  initial begin
    clk = 0;
    rst_n = 0;
    flush_i = 0;
    wake_i = 0;
    wb_ready_i = 1;
    issue_valid_i = 0;
    issue_type_i = 0;
    issue_op_i = 0;
    issue_src0_i = 0;
    issue_src1_i = 0;
    issue_imm_i = 0;
    issue_pc_i = 0;
    issue_npc_i = 0;
    issue_rd_i = 0;
    issue_rd_valid_i = 0;
    errors = 0;
    checks = 0;
    issued = 0;
    committed = 0;
    flushed = 0;
    ready_mode = 0;
    last_vl = 0;
    shadow_csr[0] = 0;
    shadow_csr[1] = 0;
    shadow_csr[2] = 0;
    shadow_csr[3] = 32'h0000_0005;  // tid reset value
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1;
    @(negedge clk);

    // every branch op a few times
    for (int i = 0; i < 36; i++) rand_branch(5'(i % 9));
    drain();

    // csr ops with drains between dependent ones
    issue_instr(misc_pkg::CNT, misc_pkg::RDCNTVH, 0, 0, 0, 0, 0, 5'd3, 1);
    issue_instr(misc_pkg::CNT, misc_pkg::RDCNTID, 0, 0, 0, 0, 0, 5'd4, 1);
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRWR, 32'h1234_5678, 0, 32'h30, 0, 0, 5'd5, 1);
    drain();
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRXCHG, 32'hffff_0000, 32'h00ff_ff00,
                32'h30, 0, 0, 5'd6, 1);
    drain();
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRRD, 0, 0, 32'h30, 0, 0, 5'd7, 1);
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRRD, 0, 0, 32'h123, 0, 0, 5'd8, 1);  // unmapped
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRWR, 32'h0000_4000, 0, 32'h6, 0, 0, 5'd9, 1);
    drain();
    issue_instr(misc_pkg::PRIV, misc_pkg::CSRXCHG, 32'h0000_0ff0, 32'h0000_00f0,
                32'h6, 0, 0, 5'd10, 1);
    drain();
    issue_instr(misc_pkg::PRIV, misc_pkg::ERTN, 0, 0, 0, 0, 0, 5'd0, 0);
    drain();

    // counter growth
    for (int i = 0; i < 6; i++) begin
      issue_instr(misc_pkg::CNT, misc_pkg::RDCNTVL, 0, 0, 0, 0, 0, 5'd11, 1);
      repeat (i) @(negedge clk);
    end
    drain();

    // back to back issues under random back-pressure
    ready_mode = 1;
    for (int i = 0; i < 30; i++) rand_branch(5'($unsigned($random(seed)) % 9));
    drain();
    ready_mode = 0;
    @(negedge clk);

    // ================ idle and wake =================
    issue_instr(misc_pkg::PRIV, misc_pkg::IDLE, 0, 0, 0, 0, 0, 5'd0, 0);
    drain();
    @(negedge clk);
    check_val("idle_o", idle_o, 1);
    issue_valid_i = 1;  // offered while idle, must not be taken
    for (int i = 0; i < 8; i++) begin
      check_val("issue_ready_o", issue_ready_o, 0);
      @(negedge clk);
    end
    issue_valid_i = 0;
    wake_i = 1;
    @(negedge clk);
    wake_i = 0;
    rand_branch(misc_pkg::BL);
    drain();
    check_val("idle_o", idle_o, 0);

    // ================ flush with two in flight =================
    ready_mode = 2;
    @(negedge clk);
    rand_branch(misc_pkg::BEQ);
    rand_branch(misc_pkg::JIRL);
    flush_i = 1;
    exp_q.delete();
    flushed = 2;
    @(negedge clk);
    flush_i = 0;
    ready_mode = 0;
    repeat (4) @(negedge clk);
    rand_branch(misc_pkg::BNE);
    drain();
    repeat (4) @(negedge clk);
    check_val("commit_count", committed, issued - flushed);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== misc_unit_top.f ====
src/misc_pkg.sv
src/misc_if.sv
src/branch_unit.sv
src/stable_counter.sv
src/csr_regs.sv
src/idle_fsm.sv
src/misc_pipe.sv
src/misc_unit_top.sv
verif/misc_unit_asserts.sv
verif/misc_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= misc_unit_tb
FLIST     ?= misc_unit_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean
